// File: rtl/branch_pkg.sv
// Branch resolution types
`default_nettype none

package branch_pkg;

    ///////////////////////////////
    // Widths and codes
    ///////////////////////////////

    // Data and address width
    localparam int XLEN = 32;

    // Instruction address misaligned, mcause 0
    localparam logic [3:0] EXC_INST_ADDR_MISALIGNED = 4'd0;

    // Control transfer flavour
    typedef enum logic [1:0] {
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR
    } branch_kind_e;

    ///////////////////////////////
    // Issue and result records
    ///////////////////////////////

    // Operation held stable while req is high
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        // Already sign extended by decode
        logic [XLEN-1:0] offset;
        logic [2:0]      fn3;
        branch_kind_e    kind;
        logic            is_call;
        logic            is_return;
    } branch_op_t;

    // Resolution, valid with res_valid
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] new_pc;
        logic            taken;
        logic            is_branch;
        logic            is_call;
        logic            is_return;
        logic            flush;
    } branch_result_t;

    // Exception record, valid with exc_valid
    typedef struct packed {
        logic [3:0]      code;
        logic [XLEN-1:0] tval;
    } branch_exc_t;

endpackage

`default_nettype wire

// File: rtl/branch_comparator.sv
// Conditional branch comparator
`timescale 1ns/1ps
`default_nettype none

module branch_comparator (
    input  wire logic [branch_pkg::XLEN-1:0] rs1,
    input  wire logic [branch_pkg::XLEN-1:0] rs2,
    input  wire logic [2:0]                  fn3,
    output logic                             cond_true
);

    import branch_pkg::*;

    // One extra bit so a single signed compare covers both modes
    logic signed [XLEN:0] a_ext;
    logic signed [XLEN:0] b_ext;
    logic                 use_signed;
    logic                 less_than;
    logic                 equal;
    logic                 raw;

    // fn3[1] clear selects BLT/BGE, set selects BLTU/BGEU
    assign use_signed = ~fn3[1];

    // Sign or zero extend
    assign a_ext = {use_signed & rs1[XLEN-1], rs1};
    assign b_ext = {use_signed & rs2[XLEN-1], rs2};

    assign less_than = a_ext < b_ext;
    assign equal     = (rs1 == rs2);

    // fn3[2] picks the relation, fn3[0] negates it
    assign raw       = fn3[2] ? less_than : equal;
    assign cond_true = raw ^ fn3[0];

endmodule

`default_nettype wire

// File: rtl/branch_target.sv
// Branch and jump target unit
`timescale 1ns/1ps
`default_nettype none

module branch_target (
    input  wire branch_pkg::branch_op_t      op,
    input  wire logic                        cond_true,
    output logic                             taken,
    output logic [branch_pkg::XLEN-1:0]      new_pc,
    output logic                             misaligned
);

    import branch_pkg::*;

    logic            is_jalr;
    logic            is_cond;
    logic [XLEN-1:0] jump_base;
    logic [XLEN-1:0] addend;
    logic [XLEN-1:0] sum;

    assign is_jalr = (op.kind == KIND_JALR);
    assign is_cond = (op.kind == KIND_BRANCH);

    ///////////////////////////////
    // Direction
    ///////////////////////////////

    // Unconditional jumps always redirect
    assign taken = is_cond ? cond_true : 1'b1;

    ///////////////////////////////
    // Address
    ///////////////////////////////

    // JALR is register relative, everything else pc relative
    assign jump_base = is_jalr ? op.rs1 : op.pc;

    // Fall through is pc+4, no compressed support
    assign addend = taken ? op.offset : XLEN'(4);
    assign sum    = jump_base + addend;

    // JALR drops the low bit of the sum
    assign new_pc = {sum[XLEN-1:1], sum[0] & ~is_jalr};

    // Only a taken transfer can fault
    assign misaligned = taken & new_pc[1];

endmodule

`default_nettype wire

// File: rtl/branch_ctrl.sv
// Branch resolution controller
`timescale 1ns/1ps
`default_nettype none

module branch_ctrl (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    // Issue handshake
    input  wire logic                        req,
    input  wire branch_pkg::branch_op_t      op,
    output logic                             ack,
    // From comparator and target unit
    input  wire logic                        taken,
    input  wire logic [branch_pkg::XLEN-1:0] new_pc,
    input  wire logic                        misaligned,
    // Following instruction
    input  wire logic                        next_valid,
    input  wire logic [branch_pkg::XLEN-1:0] next_pc,
    // Resolution and exception
    output logic                             res_valid,
    output branch_pkg::branch_result_t       res,
    output logic                             exc_valid,
    output branch_pkg::branch_exc_t          exc
);

    import branch_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_NEXT
    } state_e;

    state_e state;

    // Execute stage registers
    logic [XLEN-1:0] pc_ex;
    logic [XLEN-1:0] new_pc_ex;
    logic            taken_ex;
    branch_kind_e    kind_ex;
    logic            is_call_ex;
    logic            is_return_ex;
    logic            misaligned_ex;
    logic            flush_q;

    logic            accept;
    logic            resolve;

    assign accept  = (state == IDLE) && req;
    assign resolve = (state == WAIT_NEXT) && next_valid;

    ///////////////////////////////
    // Handshake FSM
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            ack       <= 1'b0;
            res_valid <= 1'b0;
            exc_valid <= 1'b0;
        end else begin
            // Pulses by default
            res_valid <= 1'b0;
            exc_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (req) begin
                        ack   <= 1'b1;
                        state <= ACK;
                    end
                end
                ACK: begin
                    // Issuer released req, close the handshake
                    if (!req) begin
                        ack <= 1'b0;
                        if (misaligned_ex) begin
                            // Fault replaces resolution
                            exc_valid <= 1'b1;
                            state     <= IDLE;
                        end else begin
                            state <= WAIT_NEXT;
                        end
                    end
                end
                WAIT_NEXT: begin
                    // Stall here until fetch reports the next address
                    if (next_valid) begin
                        res_valid <= 1'b1;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    ///////////////////////////////
    // Execute registers
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_ex         <= op.pc;
            new_pc_ex     <= new_pc;
            taken_ex      <= taken;
            kind_ex       <= op.kind;
            is_call_ex    <= op.is_call;
            is_return_ex  <= op.is_return;
            misaligned_ex <= misaligned;
        end
        // Bit 0 never matters for a fetch address
        if (resolve) begin
            flush_q <= (next_pc[XLEN-1:1] != new_pc_ex[XLEN-1:1]);
        end
    end

    ///////////////////////////////
    // Outputs
    ///////////////////////////////

    assign res = '{
        pc:        pc_ex,
        new_pc:    new_pc_ex,
        taken:     taken_ex,
        is_branch: (kind_ex == KIND_BRANCH),
        is_call:   is_call_ex,
        is_return: is_return_ex,
        flush:     flush_q
    };

    assign exc = '{code: EXC_INST_ADDR_MISALIGNED, tval: new_pc_ex};

endmodule

`default_nettype wire

// File: rtl/branch_stats.sv
// Branch trace counters
`timescale 1ns/1ps
`default_nettype none

module branch_stats #(
    parameter int CNT_W = 8
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       res_valid,
    input  wire branch_pkg::branch_result_t res,
    output logic [CNT_W-1:0]                branch_ok,
    output logic [CNT_W-1:0]                branch_miss,
    output logic [CNT_W-1:0]                return_ok,
    output logic [CNT_W-1:0]                return_miss
);

    localparam logic [CNT_W-1:0] CNT_MAX = '1;

    // 0 branch ok, 1 branch miss, 2 return ok, 3 return miss
    logic [CNT_W-1:0] cnt [4];
    logic [3:0]       hit;

    ///////////////////////////////
    // Event decode
    ///////////////////////////////

    // Exactly one class per resolution
    always_comb begin
        hit = '0;
        hit[{res.is_return, res.flush}] = res_valid;
    end

    ///////////////////////////////
    // Saturating counters
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                // Stick at all ones
                if (hit[i] && cnt[i] != CNT_MAX) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    assign branch_ok   = cnt[0];
    assign branch_miss = cnt[1];
    assign return_ok   = cnt[2];
    assign return_miss = cnt[3];

endmodule

`default_nettype wire

// File: rtl/branch_resolve_top.sv
// Branch resolution subsystem
`timescale 1ns/1ps
`default_nettype none

module branch_resolve_top #(
    parameter int CNT_W = 8
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    // Issue side
    input  wire logic                        req,
    input  wire branch_pkg::branch_op_t      op,
    output logic                             ack,
    // Next fetch address
    input  wire logic                        next_valid,
    input  wire logic [branch_pkg::XLEN-1:0] next_pc,
    // Resolution
    output logic                             res_valid,
    output branch_pkg::branch_result_t       res,
    output logic                             exc_valid,
    output branch_pkg::branch_exc_t          exc,
    // Trace counters
    output logic [CNT_W-1:0]                 branch_ok,
    output logic [CNT_W-1:0]                 branch_miss,
    output logic [CNT_W-1:0]                 return_ok,
    output logic [CNT_W-1:0]                 return_miss
);

    import branch_pkg::*;

    logic            cond_true;
    logic            taken;
    logic [XLEN-1:0] new_pc;
    logic            misaligned;

    // Issue time evaluation, purely combinational
    branch_comparator u_comparator (
        .rs1       (op.rs1),
        .rs2       (op.rs2),
        .fn3       (op.fn3),
        .cond_true (cond_true)
    );

    branch_target u_target (
        .op         (op),
        .cond_true  (cond_true),
        .taken      (taken),
        .new_pc     (new_pc),
        .misaligned (misaligned)
    );

    // Handshake and execute stage
    branch_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .op         (op),
        .ack        (ack),
        .taken      (taken),
        .new_pc     (new_pc),
        .misaligned (misaligned),
        .next_valid (next_valid),
        .next_pc    (next_pc),
        .res_valid  (res_valid),
        .res        (res),
        .exc_valid  (exc_valid),
        .exc        (exc)
    );

    // Outcome statistics
    branch_stats #(
        .CNT_W (CNT_W)
    ) u_stats (
        .clk         (clk),
        .rst_n       (rst_n),
        .res_valid   (res_valid),
        .res         (res),
        .branch_ok   (branch_ok),
        .branch_miss (branch_miss),
        .return_ok   (return_ok),
        .return_miss (return_miss)
    );

endmodule

`default_nettype wire

// File: include/branch_tb_util.svh
// Branch testbench helpers
`ifndef BRANCH_TB_UTIL_SVH
`define BRANCH_TB_UTIL_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
endfunction

// Golden model of the resolution rules
function automatic branch_pkg::branch_result_t ref_branch(
    input  branch_pkg::branch_op_t          op,
    input  logic [branch_pkg::XLEN-1:0]     next_pc,
    output logic                            exc,
    output logic [branch_pkg::XLEN-1:0]     tval
);
    branch_pkg::branch_result_t r;
    logic                       cond;
    logic [branch_pkg::XLEN-1:0] base;
    logic [branch_pkg::XLEN-1:0] sum;
    case (op.fn3)
        3'b000:  cond = (op.rs1 == op.rs2);
        3'b001:  cond = (op.rs1 != op.rs2);
        3'b100:  cond = ($signed(op.rs1) < $signed(op.rs2));
        3'b101:  cond = ($signed(op.rs1) >= $signed(op.rs2));
        3'b110:  cond = (op.rs1 < op.rs2);
        default: cond = (op.rs1 >= op.rs2);
    endcase
    r.taken     = (op.kind == branch_pkg::KIND_BRANCH) ? cond : 1'b1;
    base        = (op.kind == branch_pkg::KIND_JALR) ? op.rs1 : op.pc;
    sum         = base + (r.taken ? op.offset : 32'd4);
    if (op.kind == branch_pkg::KIND_JALR) begin
        sum[0] = 1'b0;
    end
    r.pc        = op.pc;
    r.new_pc    = sum;
    r.is_branch = (op.kind == branch_pkg::KIND_BRANCH);
    r.is_call   = op.is_call;
    r.is_return = op.is_return;
    r.flush     = (next_pc[31:1] != sum[31:1]);
    exc         = r.taken & sum[1];
    tval        = sum;
    return r;
endfunction

// Report and count one mismatch
task automatic compare(input string test, input logic [127:0] expected,
                       input logic [127:0] actual, inout int errors);
    if (expected !== actual) begin
        $display("Mismatch in %s: expected %h, actual %h", test, expected, actual);
        errors++;
    end
endtask

`endif

// File: dv/branch_resolve_tb.sv
// Branch resolution testbench
`timescale 1ns/1ps
`default_nettype none

module branch_resolve_tb;

    import branch_pkg::*;

    `include "branch_tb_util.svh"

    localparam int CNT_W   = 4;
    localparam int TIMEOUT = 50;

    logic             clk;
    logic             rst_n;
    logic             req;
    branch_op_t       op;
    logic             ack;
    logic             next_valid;
    logic [XLEN-1:0]  next_pc;
    logic             res_valid;
    branch_result_t   res;
    logic             exc_valid;
    branch_exc_t      exc;
    logic [CNT_W-1:0] branch_ok;
    logic [CNT_W-1:0] branch_miss;
    logic [CNT_W-1:0] return_ok;
    logic [CNT_W-1:0] return_miss;

    logic [31:0]      lfsr;
    // Expected counters as 0 branch ok, 1 branch miss, 2 return ok, 3 return miss
    logic [3:0]       exp_cnt [4];
    int               errors;
    int               tests;
    int               failed;
    logic             aborted;

    branch_resolve_top #(
        .CNT_W (CNT_W)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .op          (op),
        .ack         (ack),
        .next_valid  (next_valid),
        .next_pc     (next_pc),
        .res_valid   (res_valid),
        .res         (res),
        .exc_valid   (exc_valid),
        .exc         (exc),
        .branch_ok   (branch_ok),
        .branch_miss (branch_miss),
        .return_ok   (return_ok),
        .return_miss (return_miss)
    );

    // 20 ns period
    always #10 clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // n fresh bits with one LFSR step per bit
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic branch_op_t make_op(
        input logic [31:0] pc,     input logic [31:0] rs1,
        input logic [31:0] rs2,    input logic [31:0] offset,
        input logic [2:0]  fn3,    input branch_kind_e kind,
        input logic        is_call, input logic       is_return
    );
        return '{pc: pc, rs1: rs1, rs2: rs2, offset: offset, fn3: fn3,
                 kind: kind, is_call: is_call, is_return: is_return};
    endfunction

    task automatic log_test(input string name, input int err_before);
        tests++;
        if (errors != err_before) begin
            failed++;
            $display("%s: FAIL", name);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    //////////////////////////////
    // One operation end to end
    //////////////////////////////

    // mode 0 next_pc matches, 1 flips bit 0, 2 flips bit 2
    task automatic run_op(input string name, input branch_op_t o, input int mode);
        branch_result_t exp_res;
        logic           exp_exc;
        logic [31:0]    exp_tval;
        logic [31:0]    npc;
        logic [1:0]     idx;
        int             waited;
        int             err_before;
        if (aborted) begin
            return;
        end
        err_before = errors;
        exp_res    = ref_branch(o, '0, exp_exc, exp_tval);
        npc        = exp_res.new_pc;
        case (mode)
            1:       npc[0] = ~npc[0];
            2:       npc[2] = ~npc[2];
            default: ;
        endcase
        exp_res = ref_branch(o, npc, exp_exc, exp_tval);
        // Raise req with op stable
        @(posedge clk);
        #2;
        req    = 1'b1;
        op     = o;
        waited = 0;
        while (!ack && waited < TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!ack) begin
            $display("Timeout in %s: ack never rose after req", name);
            errors++;
            aborted = 1'b1;
            log_test(name, err_before);
            return;
        end
        // Release req and report the following fetch address
        req        = 1'b0;
        next_pc    = npc;
        next_valid = 1'b1;
        waited     = 0;
        while (!res_valid && !exc_valid && waited < TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!res_valid && !exc_valid) begin
            $display("Timeout in %s: neither res_valid nor exc_valid pulsed", name);
            errors++;
            aborted = 1'b1;
            log_test(name, err_before);
            return;
        end
        compare(name, 1'b0, ack, errors);
        compare(name, exp_exc, exc_valid, errors);
        compare(name, !exp_exc, res_valid, errors);
        if (exp_exc) begin
            // Instruction address misaligned is code 0
            compare(name, {4'h0, exp_tval}, exc, errors);
        end else begin
            compare(name, exp_res, res, errors);
            idx = {exp_res.is_return, exp_res.flush};
            if (exp_cnt[idx] != 4'hf) begin
                exp_cnt[idx] = exp_cnt[idx] + 1'b1;
            end
        end
        next_valid = 1'b0;
        // Counters settle one cycle after the pulse
        @(posedge clk);
        #2;
        compare(name, 1'b0, res_valid, errors);
        compare(name, 1'b0, exc_valid, errors);
        compare(name, {exp_cnt[3], exp_cnt[2], exp_cnt[1], exp_cnt[0]},
                {return_miss, return_ok, branch_miss, branch_ok}, errors);
        log_test(name, err_before);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        logic [31:0] pc_r;
        logic [31:0] a_r;
        logic [31:0] b_r;
        logic [31:0] off_r;
        logic [2:0]  fn;
        int          err_before;
        clk        = 1'b0;
        rst_n      = 1'b0;
        req        = 1'b0;
        op         = '0;
        next_valid = 1'b0;
        next_pc    = '0;
        lfsr       = 32'd80305;
        errors     = 0;
        tests      = 0;
        failed     = 0;
        aborted    = 1'b0;
        for (int i = 0; i < 4; i++) begin
            exp_cnt[i] = '0;
        end

        // Reset held for 5 cycles with outputs checked before release
        repeat (5) @(posedge clk);
        #2;
        err_before = errors;
        compare("reset", '0, {ack, res_valid, exc_valid, branch_ok, branch_miss,
                return_ok, return_miss}, errors);
        log_test("reset", err_before);
        rst_n = 1'b1;

        // Six conditional encodings with edge then random operands
        for (int f = 0; f < 6; f++) begin
            fn = (f < 2) ? 3'(f) : 3'(f + 2);
            run_op($sformatf("cond%0d_equal", fn), make_op(32'h100, 32'h8000_0000,
                   32'h8000_0000, 32'h40, fn, KIND_BRANCH, 1'b0, 1'b0), 0);
            run_op($sformatf("cond%0d_sign_a", fn), make_op(32'h200, 32'h8000_0000,
                   32'h1, 32'hffff_ffc0, fn, KIND_BRANCH, 1'b0, 1'b0), 0);
            run_op($sformatf("cond%0d_sign_b", fn), make_op(32'h300, 32'h1,
                   32'h8000_0000, 32'h80, fn, KIND_BRANCH, 1'b0, 1'b0), 0);
            for (int k = 0; k < 6; k++) begin
                rand_bits(30, pc_r);
                pc_r = pc_r << 2;
                rand_bits(32, a_r);
                rand_bits(32, b_r);
                // Word aligned 13-bit branch immediate
                rand_bits(11, off_r);
                off_r = {{21{off_r[10]}}, off_r[10:0]} << 2;
                if (k == 0) begin
                    b_r = a_r;
                end
                run_op($sformatf("cond%0d_rand%0d", fn, k), make_op(pc_r, a_r, b_r,
                       off_r, fn, KIND_BRANCH, 1'b0, 1'b0), 0);
            end
        end

        // Jumps
        run_op("jal_call", make_op(32'h1000, 32'h0, 32'h0, 32'h100, 3'b000,
               KIND_JAL, 1'b1, 1'b0), 0);
        run_op("jal_back", make_op(32'h2000, 32'h0, 32'h0, 32'hffff_ff00, 3'b000,
               KIND_JAL, 1'b0, 1'b0), 0);
        run_op("jalr_bit0", make_op(32'h3000, 32'h4001, 32'h0, 32'h10, 3'b000,
               KIND_JALR, 1'b0, 1'b0), 0);
        run_op("jalr_neg_bit0", make_op(32'h3004, 32'h6000, 32'h0, 32'hffff_fffd,
               3'b000, KIND_JALR, 1'b0, 1'b0), 0);
        run_op("jalr_ret", make_op(32'h3008, 32'h5000, 32'h0, 32'h0, 3'b000,
               KIND_JALR, 1'b0, 1'b1), 0);

        // Flush only on bits 31 down to 1
        run_op("flush_bit2", make_op(32'h400, 32'h5, 32'h5, 32'h20, 3'b000,
               KIND_BRANCH, 1'b0, 1'b0), 2);
        run_op("noflush_bit0", make_op(32'h404, 32'h5, 32'h5, 32'h20, 3'b000,
               KIND_BRANCH, 1'b0, 1'b0), 1);
        run_op("flush_jal", make_op(32'h408, 32'h0, 32'h0, 32'h40, 3'b000,
               KIND_JAL, 1'b0, 1'b0), 2);

        // Misaligned targets fault while a not-taken one resolves
        run_op("misal_jal", make_op(32'h1000, 32'h0, 32'h0, 32'h6, 3'b000,
               KIND_JAL, 1'b0, 1'b0), 0);
        run_op("misal_beq", make_op(32'h2000, 32'h7, 32'h7, 32'ha, 3'b000,
               KIND_BRANCH, 1'b0, 1'b0), 0);
        run_op("misal_jalr", make_op(32'h2004, 32'h7001, 32'h0, 32'h1, 3'b000,
               KIND_JALR, 1'b0, 1'b0), 0);
        run_op("misal_not_taken", make_op(32'h2008, 32'h7, 32'h7, 32'h6, 3'b001,
               KIND_BRANCH, 1'b0, 1'b0), 0);

        // Drive every class past 15
        for (int k = 0; k < 17; k++) begin
            run_op($sformatf("ret_ok%0d", k), make_op(32'h500, 32'h8000, 32'h0,
                   32'h0, 3'b000, KIND_JALR, 1'b0, 1'b1), 0);
            run_op($sformatf("ret_miss%0d", k), make_op(32'h504, 32'h8000, 32'h0,
                   32'h0, 3'b000, KIND_JALR, 1'b0, 1'b1), 2);
            run_op($sformatf("br_miss%0d", k), make_op(32'h508, 32'h3, 32'h3,
                   32'h20, 3'b000, KIND_BRANCH, 1'b0, 1'b0), 2);
        end
        err_before = errors;
        compare("saturation", 16'hffff, {return_miss, return_ok, branch_miss, branch_ok},
                errors);
        log_test("saturation", err_before);

        $display("Tests run %0d, failed %0d, mismatches %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
rtl/branch_pkg.sv
rtl/branch_comparator.sv
rtl/branch_target.sv
rtl/branch_ctrl.sv
rtl/branch_stats.sv
rtl/branch_resolve_top.sv
dv/branch_resolve_tb.sv

// File: Bender.yml
package:
  name: branch_resolve

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - rtl/branch_pkg.sv
      - rtl/branch_comparator.sv
      - rtl/branch_target.sv
      - rtl/branch_ctrl.sv
      - rtl/branch_stats.sv
      - rtl/branch_resolve_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - dv/branch_resolve_tb.sv
